// File: test/placement_stim.txt
// cmd (0 request, 1 reset, 2 end) player type x y vertical orientation
// outcome (0 saved, 1 border, 2 overlap), all hex
0 0 0 9 0 0 0 1
0 0 1 8 0 0 0 1
0 0 1 0 8 1 0 1
0 0 3 6 2 0 0 1
0 0 3 2 6 1 0 1
0 0 4 5 0 0 0 1
0 0 4 0 5 1 0 1
0 0 2 3 0 0 0 1
0 0 2 7 4 0 1 1
0 0 2 3 7 0 2 1
0 0 2 0 3 0 3 1
0 0 5 0 0 0 0 1
0 0 6 0 0 0 0 1
0 0 7 0 0 0 0 1
0 0 4 4 8 0 0 0
0 0 3 8 0 1 0 0
0 0 1 0 0 0 0 0
0 0 0 5 5 0 0 0
0 0 2 1 5 1 3 0
0 0 1 5 4 1 0 2
0 0 0 5 4 0 0 0
0 1 0 5 5 0 0 0
0 0 3 5 8 0 0 2
1 0 0 0 0 0 0 0
0 0 3 5 8 0 0 0
2 0 0 0 0 0 0 0

// File: tb.f
+incdir+common
common/shipPkg.sv
common/validatorPkg.sv
placement/pieceDecoder.sv
placement/overlapScanner.sv
fleet/fleetStore.sv
source/validatorControl.sv
source/placementValidator.sv
test/placementValidatorTb.sv

// File: Makefile
SHELL := /bin/bash

VERILATOR ?= verilator
TOP       ?= placementValidatorTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= SIMULATION FAILED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails if the log reports failure"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Test failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/placementValidatorTb.sv
module placementValidatorTb import validatorPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MaxRecords     = 64;
	localparam int RecordWidth    = 8;
	localparam int RequestTimeout = 40;
	// Flags drop two edges after enable falls, sampled on falling edges
	localparam int ClearTimeout   = 3;
	localparam int HoldCycles     = 3;

	logic             clk;
	logic             reset;
	logic             enable;
	placementRequestT request;
	placementResultT  result;
	logic             conflict;

	logic [7:0] stim [MaxRecords * RecordWidth];
	int         valueErrors;
	int         waitErrors;

	placementValidator UUT (
		.clk      (clk),
		.reset    (reset),
		.enable   (enable),
		.request  (request),
		.result   (result),
		.conflict (conflict)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ****************************************
	// Helpers
	// ****************************************

	task automatic applyReset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic checkFlag(string name, string flag, logic expected, logic actual);
		assert (actual === expected)
		else
		begin
			valueErrors++;
			$display("ERR %s %s expected %0b actual %0b", name, flag, expected, actual);
		end
	endtask

	task automatic runRequest(int rec);
		int              base;
		int              waited;
		string           name;
		placementResultT expected;

		base = rec * RecordWidth;
		name = $sformatf("record %0d player %0d type %0d at (%0d,%0d)", rec,
			stim[base + 1], stim[base + 2], stim[base + 3], stim[base + 4]);
		// Outcome column: 0 saved, 1 border, 2 overlap
		expected.ready           = (stim[base + 7] == 8'd0);
		expected.borderConflict  = (stim[base + 7] == 8'd1);
		expected.overlapConflict = (stim[base + 7] == 8'd2);

		@(posedge clk);
		request.player      <= stim[base + 1][0];
		request.shipType    <= stim[base + 2][2:0];
		request.x           <= stim[base + 3][3:0];
		request.y           <= stim[base + 4][3:0];
		request.vertical    <= stim[base + 5][0];
		request.orientation <= stim[base + 6][1:0];
		enable              <= 1'b1;

		waited = 0;
		do
		begin
			@(negedge clk);
			waited++;
		end
		while (!(result.ready || conflict) && waited < RequestTimeout);

		if (!(result.ready || conflict))
		begin
			waitErrors++;
			$display("No result within %0d cycles for %s", RequestTimeout, name);
		end
		else
		begin
			// Result must stay put while enable is held
			for (int i = 0; i <= HoldCycles; i++)
			begin
				checkFlag(name, "ready", expected.ready, result.ready);
				checkFlag(name, "borderConflict", expected.borderConflict,
					result.borderConflict);
				checkFlag(name, "overlapConflict", expected.overlapConflict,
					result.overlapConflict);
				checkFlag(name, "conflict",
					expected.borderConflict | expected.overlapConflict, conflict);
				@(negedge clk);
			end
		end

		@(posedge clk);
		enable <= 1'b0;
		waited = 0;
		do
		begin
			@(negedge clk);
			waited++;
		end
		while ((result != '0 || conflict) && waited < ClearTimeout);

		if (result != '0 || conflict)
		begin
			waitErrors++;
			$display("Result flags still high two cycles after enable fell for %s", name);
		end

		repeat ($urandom % 4 + 1) @(posedge clk);
	endtask

	// ****************************************
	// Main sequence
	// ****************************************

	initial
	begin
		int rec;
		logic done;

		reset       = 1'b1;
		enable      = 1'b0;
		request     = '0;
		valueErrors = 0;
		waitErrors  = 0;
		rec         = 0;
		done        = 1'b0;
		void'($urandom(78));
		$readmemh("test/placement_stim.txt", stim);

		applyReset();

		while (!done && rec < MaxRecords)
		begin
			case (stim[rec * RecordWidth])
				8'd0: runRequest(rec);
				8'd1: applyReset();
				8'd2: done = 1'b1;
				default:
				begin
					waitErrors++;
					$display("Stimulus record %0d has an unknown command", rec);
					done = 1'b1;
				end
			endcase
			rec++;
		end

		$display("Errors: %0d wrong values, %0d other failures", valueErrors, waitErrors);
		if (valueErrors == 0 && waitErrors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: source/placementValidator.sv
`include "fleet_config.svh"

module placementValidator import shipPkg::*, validatorPkg::*;
(
	input  logic             clk,
	input  logic             reset,
	input  logic             enable,
	input  placementRequestT request,
	output placementResultT  result,
	output logic             conflict
);

	logic decodeStart;
	logic scanStart;
	logic commit;
	logic offBoard;
	logic scanDone;
	logic hit;

	pieceT piece;
	pieceT readPiece;

	logic [`PIECE_INDEX_WIDTH-1:0] readIndex;
	logic [`PIECE_COUNT_WIDTH-1:0] storedCount;

	validatorControl control (
		.clk         (clk),
		.reset       (reset),
		.enable      (enable),
		.offBoard    (offBoard),
		.scanDone    (scanDone),
		.hit         (hit),
		.decodeStart (decodeStart),
		.scanStart   (scanStart),
		.commit      (commit),
		.result      (result)
	);

	pieceDecoder decoder (
		.clk         (clk),
		.reset       (reset),
		.decodeStart (decodeStart),
		.request     (request),
		.piece       (piece),
		.offBoard    (offBoard)
	);

	overlapScanner scanner (
		.clk         (clk),
		.reset       (reset),
		.scanStart   (scanStart),
		.piece       (piece),
		.readPiece   (readPiece),
		.storedCount (storedCount),
		.readIndex   (readIndex),
		.scanDone    (scanDone),
		.hit         (hit)
	);

	fleetStore store (
		.clk         (clk),
		.reset       (reset),
		.commit      (commit),
		.player      (request.player),
		.piece       (piece),
		.readIndex   (readIndex),
		.readPiece   (readPiece),
		.storedCount (storedCount)
	);

	assign conflict = result.borderConflict | result.overlapConflict;

endmodule

// File: source/validatorControl.sv
`include "fleet_config.svh"

module validatorControl import validatorPkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  logic            enable,
	input  logic            offBoard,
	input  logic            scanDone,
	input  logic            hit,
	output logic            decodeStart,
	output logic            scanStart,
	output logic            commit,
	output placementResultT result
);

	validatorStateT state;
	validatorStateT nextState;

	// ****************************************
	// Next state
	// ****************************************

	always_comb
	begin
		nextState = state;
		case (state)
			stateIdle:
				if (enable)
					nextState = stateDecode;
			stateDecode:
				if (!enable)
					nextState = stateIdle;
				else if (offBoard)
					nextState = stateBorderHold;
				else
					nextState = stateScan;
			stateScan:
				if (!enable)
					nextState = stateIdle;
				else if (scanDone)
					nextState = hit ? stateOverlapHold : stateCommit;
			stateCommit:
				nextState = enable ? stateSavedHold : stateIdle;
			stateBorderHold, stateOverlapHold, stateSavedHold:
				if (!enable)
					nextState = stateIdle;
			default:
				nextState = stateIdle;
		endcase
	end

	// Strobes to the datapath drop as soon as enable falls
	assign decodeStart = (state == stateIdle) && enable;
	assign scanStart   = (state == stateDecode) && enable && !offBoard;
	assign commit      = (state == stateCommit) && enable;

	// ****************************************
	// State and result registers
	// ****************************************

	// Flags follow the hold state one edge late
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state  <= stateIdle;
			result <= '0;
		end
		else
		begin
			state                  <= nextState;
			result.ready           <= (state == stateSavedHold);
			result.borderConflict  <= (state == stateBorderHold);
			result.overlapConflict <= (state == stateOverlapHold);
		end
	end

	// One outcome per request until the flags drop
	resultExclusive: assert property (
		@(posedge clk) disable iff (reset)
		result != '0 |=> result == '0 || result == $past(result)
	) else $error("result flag changed to another outcome without clearing");

endmodule

// File: fleet/fleetStore.sv
`include "fleet_config.svh"

module fleetStore import shipPkg::*;
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          commit,
	input  logic                          player,
	input  pieceT                         piece,
	input  logic [`PIECE_INDEX_WIDTH-1:0] readIndex,
	output pieceT                         readPiece,
	output logic [`PIECE_COUNT_WIDTH-1:0] storedCount
);

	// One bank per player
	pieceT                         bank      [2][`MAX_PIECES];
	logic [`PIECE_COUNT_WIDTH-1:0] fillCount [2];

	// Reads follow the player of the current request
	assign storedCount = fillCount[player];
	assign readPiece   = bank[player][readIndex];

	// ****************************************
	// Append on commit
	// ****************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fillCount[0] <= '0;
			fillCount[1] <= '0;
		end
		else if (commit)
			fillCount[player] <= fillCount[player] + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (commit)
			bank[player][fillCount[player]] <= piece;
	end

	// Controller never commits into a full fleet
	noCommitWhenFull: assert property (
		@(posedge clk) disable iff (reset)
		commit |-> fillCount[player] < `MAX_PIECES
	) else $error("commit into a full fleet bank");

endmodule

// File: placement/overlapScanner.sv
`include "fleet_config.svh"

module overlapScanner import shipPkg::*;
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          scanStart,
	input  pieceT                         piece,
	input  pieceT                         readPiece,
	input  logic [`PIECE_COUNT_WIDTH-1:0] storedCount,
	output logic [`PIECE_INDEX_WIDTH-1:0] readIndex,
	output logic                          scanDone,
	output logic                          hit
);

	logic                          active;
	logic                          entryValid;
	logic                          cellMatch;
	logic [`PIECE_COUNT_WIDTH-1:0] nextIndex;

	assign entryValid = readIndex < storedCount;
	assign nextIndex  = readIndex + 1'b1;

	// Every occupied cell against every occupied cell of the stored entry
	always_comb
	begin
		cellMatch = 1'b0;
		for (int i = 0; i < `MAX_CELLS; i++)
		begin
			for (int j = 0; j < `MAX_CELLS; j++)
			begin
				if (i < piece.cellCount && j < readPiece.cellCount &&
					piece.cells[i] == readPiece.cells[j])
					cellMatch = 1'b1;
			end
		end
		cellMatch = cellMatch && entryValid;
	end

	// A new start always wins over a scan still running
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			active    <= 1'b0;
			readIndex <= '0;
			scanDone  <= 1'b0;
			hit       <= 1'b0;
		end
		else
		begin
			scanDone <= 1'b0;
			hit      <= 1'b0;
			if (scanStart)
			begin
				active    <= 1'b1;
				readIndex <= '0;
			end
			else if (active)
			begin
				if (cellMatch || nextIndex >= storedCount)
				begin
					active   <= 1'b0;
					scanDone <= 1'b1;
					hit      <= cellMatch;
				end
				else
					readIndex <= readIndex + 1'b1;
			end
		end
	end

	// Fill count from the store keeps the walk inside the bank
	indexInRange: assert property (
		@(posedge clk) disable iff (reset)
		readIndex < `MAX_PIECES
	) else $error("read index beyond fleet bank");

endmodule

// File: placement/pieceDecoder.sv
`include "fleet_config.svh"

module pieceDecoder import shipPkg::*, validatorPkg::*;
(
	input  logic             clk,
	input  logic             reset,
	input  logic             decodeStart,
	input  placementRequestT request,
	output pieceT            piece,
	output logic             offBoard
);

	// One extra bit so that x-1 at zero and x+4 at the edge both land off the board
	localparam int WideWidth = `COORD_WIDTH + 1;

	logic [WideWidth-1:0] anchorX;
	logic [WideWidth-1:0] anchorY;
	logic [WideWidth-1:0] cellX [`MAX_CELLS];
	logic [WideWidth-1:0] cellY [`MAX_CELLS];
	cellCountT            cellCount;
	logic                 straight;
	logic                 knownType;
	logic                 outside;
	pieceT                nextPiece;

	always_comb
	begin
		anchorX   = {1'b0, request.x};
		anchorY   = {1'b0, request.y};
		cellCount = '0;
		straight  = 1'b1;
		knownType = 1'b1;
		case (request.shipType)
			shipSubmarine:  cellCount = cellCountT'(1);
			shipCruiser:    cellCount = cellCountT'(2);
			shipBattleship: cellCount = cellCountT'(4);
			shipCarrier:    cellCount = cellCountT'(5);
			shipSeaplane:
			begin
				cellCount = cellCountT'(3);
				straight  = 1'b0;
			end
			default:
				knownType = 1'b0;
		endcase

		// Straight ships grow along one axis
		for (int i = 0; i < `MAX_CELLS; i++)
		begin
			cellX[i] = anchorX;
			cellY[i] = anchorY;
			if (straight && request.vertical)
				cellY[i] = anchorY + WideWidth'(i);
			else if (straight)
				cellX[i] = anchorX + WideWidth'(i);
		end

		// Seaplane shape, vertical flag not used
		if (!straight)
		begin
			case (request.orientation)
				2'd0:
				begin
					cellX[1] = anchorX + 1'b1;
					cellY[1] = anchorY - 1'b1;
					cellX[2] = anchorX + 2'd2;
				end
				2'd1:
				begin
					cellX[1] = anchorX + 1'b1;
					cellY[1] = anchorY + 1'b1;
					cellX[2] = anchorX + 2'd2;
				end
				2'd2:
				begin
					cellX[1] = anchorX + 1'b1;
					cellY[1] = anchorY + 1'b1;
					cellY[2] = anchorY + 2'd2;
				end
				default:
				begin
					cellX[1] = anchorX - 1'b1;
					cellY[1] = anchorY + 1'b1;
					cellY[2] = anchorY + 2'd2;
				end
			endcase
		end

		// Border check on occupied cells only
		outside = !knownType;
		for (int i = 0; i < `MAX_CELLS; i++)
		begin
			if (i < cellCount && (cellX[i] >= `BOARD_SIZE || cellY[i] >= `BOARD_SIZE))
				outside = 1'b1;
		end

		nextPiece.shipType  = shipTypeT'(request.shipType);
		nextPiece.cellCount = cellCount;
		for (int i = 0; i < `MAX_CELLS; i++)
		begin
			nextPiece.cells[i] = '0;
			if (i < cellCount)
			begin
				nextPiece.cells[i].x = cellX[i][`COORD_WIDTH-1:0];
				nextPiece.cells[i].y = cellY[i][`COORD_WIDTH-1:0];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			offBoard <= 1'b0;
		else if (decodeStart)
			offBoard <= outside;
	end

	always_ff @(posedge clk)
	begin
		if (decodeStart)
			piece <= nextPiece;
	end

endmodule

// File: common/validatorPkg.sv
`include "fleet_config.svh"

package validatorPkg;

	// Controller states
	typedef enum logic [2:0]
	{
		stateIdle        = 3'd0,
		stateDecode      = 3'd1,
		stateScan        = 3'd2,
		stateCommit      = 3'd3,
		stateBorderHold  = 3'd4,
		stateOverlapHold = 3'd5,
		stateSavedHold   = 3'd6
	} validatorStateT;

	// Raw type code so that unknown codes can still be requested
	typedef struct packed
	{
		logic                    player;
		logic [2:0]              shipType;
		logic [`COORD_WIDTH-1:0] x;
		logic [`COORD_WIDTH-1:0] y;
		logic                    vertical;
		logic [1:0]              orientation;
	} placementRequestT;

	typedef struct packed
	{
		logic ready;
		logic borderConflict;
		logic overlapConflict;
	} placementResultT;

endpackage

// File: common/shipPkg.sv
`include "fleet_config.svh"

package shipPkg;

	// Ship codes as sent in a request
	// Codes 5 to 7 have no ship behind them
	typedef enum logic [2:0]
	{
		shipSubmarine  = 3'd0,
		shipCruiser    = 3'd1,
		shipSeaplane   = 3'd2,
		shipBattleship = 3'd3,
		shipCarrier    = 3'd4
	} shipTypeT;

	// One board square
	typedef struct packed
	{
		logic [`COORD_WIDTH-1:0] x;
		logic [`COORD_WIDTH-1:0] y;
	} cellT;

	// Number of occupied cells in a piece
	typedef logic [$clog2(`MAX_CELLS + 1)-1:0] cellCountT;

	// Stored fleet entry
	// Only the first cellCount cells are occupied, the rest are zero
	typedef struct packed
	{
		shipTypeT                  shipType;
		cellCountT                 cellCount;
		cellT [`MAX_CELLS-1:0]     cells;
	} pieceT;

endpackage

// File: common/fleet_config.svh
`ifndef FLEET_CONFIG_SVH
`define FLEET_CONFIG_SVH

// Board geometry
`define BOARD_SIZE 9
`define COORD_WIDTH 4

// Largest piece, the carrier
`define MAX_CELLS 5

// Fleet capacity per player
`define MAX_PIECES 12

// Slot index and fill count widths follow the capacity
`define PIECE_INDEX_WIDTH ($clog2(`MAX_PIECES))
`define PIECE_COUNT_WIDTH ($clog2(`MAX_PIECES + 1))

`endif
